//--- Makefile
# Verilator flow for the memory harness

VERILATOR  ?= verilator
TOP        ?= tb_harness
RTL_TOP    ?= harness_top
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then \
	  echo "Simulation reported a failure"; exit 1; \
	fi
	@grep -q "all tests passed" $(LOG) || \
	  (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/harness_properties.sv
`timescale 1ns/1ps

module harness_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic sys_rst_no,
  input logic rvalid_o,
  input logic debug_req_i,
  input logic debug_enable_i,
  input logic debug_req_o
);

  // ----------------------------------------------------------
  // Bus response
  // ----------------------------------------------------------

  // One response per accepted request, one cycle later
  property p_resp_follows_req;
    @(posedge clk_i) disable iff (!rst_ni)
      (req_i && sys_rst_no) |=> rvalid_o;
  endproperty

  // Nothing comes back while the system is held in reset
  property p_quiet_in_reset;
    @(posedge clk_i) disable iff (!rst_ni)
      !sys_rst_no |-> !rvalid_o;
  endproperty

  a_resp_follows_req: assert property (p_resp_follows_req)
    else $error("rvalid_o missing one cycle after an accepted request");

  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else $error("rvalid_o high while sys_rst_no is low");

  // ----------------------------------------------------------
  // Debug gate
  // ----------------------------------------------------------

  a_debug_gated: assert property (
    @(posedge clk_i) debug_req_o |-> (debug_req_i && debug_enable_i))
    else $error("debug_req_o high without an enabled halt request");

endmodule

//--- dv/tb_harness.sv
`timescale 1ns/1ps

module tb_harness;
  import bus_pkg::*;
  import soc_map_pkg::*;

  localparam int unsigned Seed      = 32'h47311f40;
  localparam int unsigned WordBytes = DataWidth / 8;
  localparam int unsigned RamTests  = 12;

  // Cycle budget of each test
  localparam int unsigned ResetCycles = 4;
  localparam int unsigned DebugCycles = 35;
  localparam int unsigned RomCycles   = RomWords + 8;
  localparam int unsigned RamCycles   = 3 * RamTests + 6;
  localparam int unsigned ErrCycles   = 2 * 7 + 6;
  localparam int unsigned NdmCycles   = RamTests + 20;
  localparam int unsigned TotalCycles = ResetCycles + DebugCycles + RomCycles
                                      + RamCycles + ErrCycles + NdmCycles;

  logic  clk_i = 1'b0;
  logic  rst_ni;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  strb_t be_i;
  data_t wdata_i;
  logic  ndmreset_i;
  logic  debug_req_i;
  logic  debug_enable_i;
  logic  rvalid_o;
  data_t rdata_o;
  logic  err_o;
  logic  sys_rst_no;
  logic  debug_req_o;

  // Reference state
  data_t       shadow_ram [RamWords];
  bit          exp_valid = 1'b0;
  bit          exp_err;
  data_t       exp_rdata;
  addr_t       ram_addr [RamTests];
  int unsigned cycle_cnt = 0;

  // Expected system reset, counts edges since both sources went inactive
  int unsigned rel_edges = 0;
  bit          sys_up;

  // GPIO window, region edges and the top of the address space
  addr_t unmapped_addr [7] = '{
    32'h4000_0000, 32'h4000_1008, 32'h0000_0000,
    RomBase + RomWords * WordBytes, RamBase - WordBytes,
    RamBase + RamWords * WordBytes, 32'hFFFF_FFF8
  };

  harness_top dut0 (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req_i          ),
    .we_i           ( we_i           ),
    .addr_i         ( addr_i         ),
    .be_i           ( be_i           ),
    .wdata_i        ( wdata_i        ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .rvalid_o       ( rvalid_o       ),
    .rdata_o        ( rdata_o        ),
    .err_o          ( err_o          ),
    .sys_rst_no     ( sys_rst_no     ),
    .debug_req_o    ( debug_req_o    )
  );

  bind harness_top harness_properties u_props (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req_i          ),
    .sys_rst_no     ( sys_rst_no     ),
    .rvalid_o       ( rvalid_o       ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

  always #5 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // Failure handling and compare tasks
  // ----------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s got %h expected %h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s got %b expected %b",
                          $time, name, got, exp));
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= 2 * TotalCycles) begin
      abort_run($sformatf("Timeout after %0d cycles, tests did not finish", cycle_cnt));
    end
  end

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  function automatic bit in_rom(input addr_t addr);
    return (addr >= RomBase) && (addr < RomBase + RomWords * WordBytes);
  endfunction

  function automatic bit in_ram(input addr_t addr);
    return (addr >= RamBase) && (addr < RamBase + RamWords * WordBytes);
  endfunction

  function automatic data_t predict_resp(input logic we, input addr_t addr, output bit err);
    int unsigned idx;
    err = 1'b0;
    if (in_rom(addr)) begin
      idx = (addr - RomBase) / WordBytes;
      err = we;
      return we ? data_t'(0) : {RomSignature, idx};
    end
    if (in_ram(addr)) begin
      idx = (addr - RamBase) / WordBytes;
      return we ? data_t'(0) : shadow_ram[idx];
    end
    err = 1'b1;
    return '0;
  endfunction

  function automatic void store_shadow(input addr_t addr, input strb_t be, input data_t wdata);
    int unsigned idx;
    idx = (addr - RamBase) / WordBytes;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        shadow_ram[idx][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
  endfunction

  // Check last cycle's prediction, then predict from the inputs the next edge takes
  always @(negedge clk_i) begin
    if (exp_valid) begin
      check_bit("rvalid_o", rvalid_o, 1'b1);
      check_bit("err_o", err_o, exp_err);
      check_data("rdata_o", rdata_o, exp_rdata);
    end else begin
      check_bit("rvalid_o", rvalid_o, 1'b0);
    end
    // Released on the second edge with both reset sources inactive
    sys_up = rst_ni && !ndmreset_i && (rel_edges >= 2);
    if (rst_ni && !ndmreset_i) begin
      if (rel_edges < 2) begin
        rel_edges++;
      end
    end else begin
      rel_edges = 0;
    end
    exp_valid = req_i && sys_up;
    if (exp_valid) begin
      exp_rdata = predict_resp(we_i, addr_i, exp_err);
      if (we_i && in_ram(addr_i)) begin
        store_shadow(addr_i, be_i, wdata_i);
      end
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  task automatic bus_req(input logic we, input addr_t addr, input strb_t be, input data_t wdata);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    be_i    <= be;
    wdata_i <= wdata;
  endtask

  task automatic bus_idle();
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic debug_step(input logic req, input logic en, input bit exp);
    @(posedge clk_i);
    debug_req_i    <= req;
    debug_enable_i <= en;
    @(negedge clk_i);
    check_bit("debug_req_o", debug_req_o, exp);
  endtask

  initial begin
    void'($urandom(Seed));
    rst_ni         = 1'b1;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    ndmreset_i     = 1'b0;
    // Halt inputs high from the start to probe the blanking window
    debug_req_i    = 1'b1;
    debug_enable_i = 1'b1;
    #1;
    rst_ni = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Debug gate
    repeat (15) begin
      @(negedge clk_i);
      check_bit("debug_req_o", debug_req_o, 1'b0);
    end
    repeat (10) @(negedge clk_i);
    check_bit("debug_req_o", debug_req_o, 1'b1);
    check_bit("sys_rst_no", sys_rst_no, 1'b1);
    debug_step(1'b0, 1'b1, 1'b0);
    debug_step(1'b1, 1'b1, 1'b1);
    debug_step(1'b1, 1'b0, 1'b0);
    debug_step(1'b0, 1'b0, 1'b0);

    // Boot ROM reads, then a rejected write
    for (int i = 0; i < RomWords; i++) begin
      bus_req(1'b0, RomBase + i * WordBytes, '1, '0);
    end
    bus_req(1'b1, RomBase + 3 * WordBytes, '1, {$urandom, $urandom});
    bus_req(1'b0, RomBase + 3 * WordBytes, '1, '0);
    bus_idle();

    // RAM full writes, partial writes, read back, all back to back
    for (int i = 0; i < RamTests; i++) begin
      ram_addr[i] = RamBase + $urandom_range(RamWords - 1, 0) * WordBytes;
      bus_req(1'b1, ram_addr[i], '1, {$urandom, $urandom});
    end
    for (int i = 0; i < RamTests; i++) begin
      bus_req(1'b1, ram_addr[i], strb_t'($urandom), {$urandom, $urandom});
    end
    for (int i = 0; i < RamTests; i++) begin
      bus_req(1'b0, ram_addr[i], '0, '0);
    end
    bus_idle();

    foreach (unmapped_addr[i]) begin
      bus_req(1'b0, unmapped_addr[i], '1, '0);
      bus_req(1'b1, unmapped_addr[i], '1, {$urandom, $urandom});
    end
    bus_idle();

    // Non-debug reset pulse with requests that must be dropped
    @(posedge clk_i);
    ndmreset_i <= 1'b1;
    @(negedge clk_i);
    check_bit("sys_rst_no", sys_rst_no, 1'b0);
    bus_req(1'b0, ram_addr[0], '1, '0);
    bus_req(1'b1, ram_addr[0], '1, {$urandom, $urandom});
    bus_req(1'b0, RomBase, '1, '0);
    bus_idle();
    @(posedge clk_i);
    ndmreset_i <= 1'b0;
    @(negedge clk_i);
    check_bit("sys_rst_no", sys_rst_no, 1'b0);
    @(negedge clk_i);
    check_bit("sys_rst_no", sys_rst_no, 1'b0);
    @(negedge clk_i);
    check_bit("sys_rst_no", sys_rst_no, 1'b1);
    for (int i = 0; i < RamTests; i++) begin
      bus_req(1'b0, ram_addr[i], '0, '0);
    end
    bus_idle();

    repeat (2) @(negedge clk_i);
    $display("all tests passed");
    $finish;
  end

endmodule

//--- hw/boot_rom.sv
`timescale 1ns/1ps

module boot_rom (
  input  logic clk_i,
  input  logic rst_ni,
  mem_if.sub   bus
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  data_t rom_mem [RomWords];
  data_t rdata_q;

  // ----------------------------------------------------------
  // Fixed contents
  // ----------------------------------------------------------

  // Signature on top, word index below
  always_comb begin
    for (int i = 0; i < RomWords; i++) begin
      rom_mem[i] = {RomSignature, 32'(i)};
    end
  end

  // ----------------------------------------------------------
  // Registered read
  // ----------------------------------------------------------

  // Writes never reach here, the decoder turns them into errors
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (bus.req && !bus.we) begin
      rdata_q <= rom_mem[bus.idx];
    end
  end

  assign bus.rdata = rdata_q;

endmodule

//--- hw/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           we_i,
  input  bus_pkg::addr_t addr_i,
  input  bus_pkg::strb_t be_i,
  input  bus_pkg::data_t wdata_i,
  output logic           rvalid_o,
  output bus_pkg::data_t rdata_o,
  output logic           err_o,
  mem_if.mgr             rom_bus,
  mem_if.mgr             ram_bus
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  // Region sizes in bytes
  localparam addr_t RomLen = addr_t'(RomWords * (DataWidth / 8));
  localparam addr_t RamLen = addr_t'(RamWords * (DataWidth / 8));

  localparam int unsigned RomIdxBits = $clog2(RomWords);
  localparam int unsigned RamIdxBits = $clog2(RamWords);

  logic    rom_hit;
  logic    ram_hit;
  logic    req_err;
  target_e target;
  target_e src_d;
  target_e src_q;
  logic    valid_q;
  logic    err_q;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------

  // Offset compare, addresses below the base wrap to large values
  assign rom_hit = (addr_i - RomBase) < RomLen;
  assign ram_hit = (addr_i - RamBase) < RamLen;

  always_comb begin
    if (rom_hit) begin
      target = TargetRom;
    end else if (ram_hit) begin
      target = TargetRam;
    end else begin
      target = TargetErr;
    end
  end

  // Unmapped space and ROM writes go to the error responder
  assign req_err = (target == TargetErr) || ((target == TargetRom) && we_i);

  // ----------------------------------------------------------
  // Request steering
  // ----------------------------------------------------------

  assign rom_bus.req   = req_i && (target == TargetRom) && !we_i;
  assign rom_bus.we    = we_i;
  assign rom_bus.idx   = addr_i[WordOffsetBits +: RomIdxBits];
  assign rom_bus.be    = be_i;
  assign rom_bus.wdata = wdata_i;

  assign ram_bus.req   = req_i && (target == TargetRam);
  assign ram_bus.we    = we_i;
  assign ram_bus.idx   = addr_i[WordOffsetBits +: RamIdxBits];
  assign ram_bus.be    = be_i;
  assign ram_bus.wdata = wdata_i;

  // ----------------------------------------------------------
  // Response
  // ----------------------------------------------------------

  // Only reads return memory data, everything else answers zero
  assign src_d = (req_i && !we_i) ? target : TargetErr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      src_q   <= TargetErr;
    end else begin
      valid_q <= req_i;
      err_q   <= req_i && req_err;
      src_q   <= src_d;
    end
  end

  always_comb begin
    case (src_q)
      TargetRom: rdata_o = rom_bus.rdata;
      TargetRam: rdata_o = ram_bus.rdata;
      default:   rdata_o = '0;
    endcase
  end

  assign rvalid_o = valid_q;
  assign err_o    = err_q;

endmodule

//--- hw/bus_pkg.sv
package bus_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------

  // Byte address width
  localparam int unsigned AddrWidth = 32;

  // One data beat is a 64-bit word
  localparam int unsigned DataWidth = 64;

  // One enable per byte lane
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Low address bits that select a byte inside a word
  localparam int unsigned WordOffsetBits = $clog2(StrbWidth);

  // ----------------------------------------------------------
  // Bus types
  // ----------------------------------------------------------

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

endpackage

//--- hw/debug_gate.sv
`timescale 1ns/1ps

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);
  import soc_map_pkg::*;

  localparam int unsigned CntWidth = $clog2(DebugBlankCycles + 1);

  logic [CntWidth-1:0] blank_cnt_q;
  logic                blank_done;

  // ----------------------------------------------------------
  // Blanking window
  // ----------------------------------------------------------

  // Gives the boot code time to run before a halt can land
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      blank_cnt_q <= CntWidth'(DebugBlankCycles);
    end else if (blank_cnt_q != '0) begin
      blank_cnt_q <= blank_cnt_q - 1'b1;
    end
  end

  assign blank_done = (blank_cnt_q == '0);

  // ----------------------------------------------------------
  // Halt request gate
  // ----------------------------------------------------------

  assign debug_req_o = debug_req_i && debug_enable_i && blank_done;

endmodule

//--- hw/harness_top.sv
`timescale 1ns/1ps

module harness_top (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           we_i,
  input  bus_pkg::addr_t addr_i,
  input  bus_pkg::strb_t be_i,
  input  bus_pkg::data_t wdata_i,
  input  logic           ndmreset_i,
  input  logic           debug_req_i,
  input  logic           debug_enable_i,
  output logic           rvalid_o,
  output bus_pkg::data_t rdata_o,
  output logic           err_o,
  output logic           sys_rst_no,
  output logic           debug_req_o
);
  import soc_map_pkg::*;

  logic sys_rst_n;

  // ----------------------------------------------------------
  // System reset
  // ----------------------------------------------------------

  reset_ctrl u_reset (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_n  )
  );

  assign sys_rst_no = sys_rst_n;

  // ----------------------------------------------------------
  // Bus and memories
  // ----------------------------------------------------------

  mem_if #(.IdxWidth($clog2(RomWords))) rom_bus ();
  mem_if #(.IdxWidth($clog2(RamWords))) ram_bus ();

  bus_decoder u_decoder (
    .clk_i    ( clk_i     ),
    .rst_ni   ( sys_rst_n ),
    .req_i    ( req_i     ),
    .we_i     ( we_i      ),
    .addr_i   ( addr_i    ),
    .be_i     ( be_i      ),
    .wdata_i  ( wdata_i   ),
    .rvalid_o ( rvalid_o  ),
    .rdata_o  ( rdata_o   ),
    .err_o    ( err_o     ),
    .rom_bus  ( rom_bus   ),
    .ram_bus  ( ram_bus   )
  );

  ram_bank u_ram (
    .clk_i  ( clk_i     ),
    .rst_ni ( sys_rst_n ),
    .bus    ( ram_bus   )
  );

  boot_rom u_rom (
    .clk_i  ( clk_i     ),
    .rst_ni ( sys_rst_n ),
    .bus    ( rom_bus   )
  );

  // ----------------------------------------------------------
  // Debug
  // ----------------------------------------------------------

  // Blanking runs from power-on reset only
  debug_gate u_debug (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

//--- hw/mem_if.sv
`timescale 1ns/1ps

interface mem_if #(
  parameter int unsigned IdxWidth = 8
);

  // Request side, driven by the decoder
  logic                req;
  logic                we;
  logic [IdxWidth-1:0] idx;
  bus_pkg::strb_t      be;
  bus_pkg::data_t      wdata;

  // Registered read data from the memory
  bus_pkg::data_t      rdata;

  modport mgr (
    output req,
    output we,
    output idx,
    output be,
    output wdata,
    input  rdata
  );

  modport sub (
    input  req,
    input  we,
    input  idx,
    input  be,
    input  wdata,
    output rdata
  );

endinterface

//--- hw/ram_bank.sv
`timescale 1ns/1ps

module ram_bank (
  input  logic clk_i,
  input  logic rst_ni,
  mem_if.sub   bus
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  data_t mem_q [RamWords];
  data_t rdata_q;

  // Byte-lane writes, array contents survive reset
  always_ff @(posedge clk_i) begin
    // No writes while the port is held in reset
    if (rst_ni && bus.req && bus.we) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (bus.be[b]) begin
          mem_q[bus.idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read port, data appears one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (bus.req && !bus.we) begin
      rdata_q <= mem_q[bus.idx];
    end
  end

  assign bus.rdata = rdata_q;

endmodule

//--- hw/reset_ctrl.sv
`timescale 1ns/1ps

module reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic       rst_src_n;
  logic [1:0] sync_q;

  // Either source pulls the system into reset
  assign rst_src_n = rst_ni && !ndmreset_i;

  // Assert at once, release after two edges
  always_ff @(posedge clk_i or negedge rst_src_n) begin
    if (!rst_src_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

//--- hw/soc_map_pkg.sv
package soc_map_pkg;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------

  // Boot ROM region
  localparam bus_pkg::addr_t RomBase  = 32'h0001_0000;
  localparam int unsigned    RomWords = 16;

  // Main memory region
  localparam bus_pkg::addr_t RamBase  = 32'h8000_0000;
  localparam int unsigned    RamWords = 256;

  // Upper half of every boot ROM word
  localparam logic [31:0] RomSignature = 32'hB007_C0DE;

  // ----------------------------------------------------------
  // Debug
  // ----------------------------------------------------------

  // Cycles after power-on reset during which halt requests are held off
  localparam int unsigned DebugBlankCycles = 20;

  // Where the decoder sends a request
  typedef enum logic [1:0] {
    TargetRom = 2'd0,
    TargetRam = 2'd1,
    TargetErr = 2'd2
  } target_e;

endpackage

//--- sources.f
hw/bus_pkg.sv
hw/soc_map_pkg.sv
hw/mem_if.sv
hw/reset_ctrl.sv
hw/debug_gate.sv
hw/ram_bank.sv
hw/boot_rom.sv
hw/bus_decoder.sv
hw/harness_top.sv
dv/harness_properties.sv
dv/tb_harness.sv
